//--- robPkg.sv
package robPkg;

    localparam int RobDepth = 8;

    // widths that carry a meaning
    typedef logic [2:0]  tagT;
    typedef logic [2:0]  regIdxT;
    typedef logic [31:0] dataT;
    typedef logic [2:0]  opCodeT;

    localparam opCodeT OpAdd = 3'd0;
    localparam opCodeT OpSub = 3'd1;
    localparam opCodeT OpXor = 3'd2;
    localparam opCodeT OpMul = 3'd3;
    // dest takes the immediate
    localparam opCodeT OpLdi = 3'd4;

    typedef struct packed {
        opCodeT op;
        regIdxT dest;
        regIdxT srcA;
        regIdxT srcB;
        dataT   imm;
    } instrT;

    // either a value or the tag of the entry that will produce it
    typedef struct packed {
        logic pending;
        tagT  tag;
        dataT value;
    } operandT;

    typedef struct packed {
        logic    valid;
        opCodeT  op;
        tagT     tag;
        regIdxT  dest;
        operandT opA;
        operandT opB;
    } issueT;

    typedef struct packed {
        logic valid;
        tagT  tag;
        dataT data;
    } wbT;

    typedef struct packed {
        logic valid;
        dataT data;
    } readPortT;

    typedef struct packed {
        logic   valid;
        tagT    tag;
        regIdxT dest;
        dataT   data;
    } commitT;

endpackage

//--- regStatus.sv
`timescale 1ns/10ps

module regStatus
    import robPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  regIdxT  srcA,
    input  regIdxT  srcB,
    output operandT opA,
    output operandT opB,
    input  logic    rename,
    input  regIdxT  renameDest,
    input  tagT     renameTag,
    input  commitT  commit
);

    dataT       regData [8];
    tagT        mapTag  [8];
    logic [7:0] pending;

    logic clearHit;

    // value of a register, or the tag it waits for
    function automatic operandT lookUp(input regIdxT idx);
        operandT res;
        res.pending = 1'b0;
        res.tag     = mapTag[idx];
        res.value   = regData[idx];
        if (pending[idx]) begin
            // the entry is already gone from the buffer while its commit is in flight
            if (commit.valid && commit.tag == mapTag[idx]) begin
                res.value = commit.data;
            end else begin
                res.pending = 1'b1;
            end
        end
        return res;
    endfunction

    always_comb begin
        opA = lookUp(srcA);
        opB = lookUp(srcB);
    end

    // only the newest writer of a register may clear its pending bit
    assign clearHit = commit.valid && pending[commit.dest] && mapTag[commit.dest] == commit.tag;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
            for (int i = 0; i < 8; i++) begin
                regData[i] <= '0;
            end
        end else begin
            if (commit.valid) begin
                regData[commit.dest] <= commit.data;
            end
            if (clearHit) begin
                pending[commit.dest] <= 1'b0;
            end
            // a rename in the same cycle wins over the clear
            if (rename) begin
                pending[renameDest] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rename) begin
            mapTag[renameDest] <= renameTag;
        end
    end

endmodule

//--- dispatchStage.sv
`timescale 1ns/10ps

module dispatchStage
    import robPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     req,
    output logic     ack,
    input  instrT    instr,
    output regIdxT   srcA,
    output regIdxT   srcB,
    input  operandT  opA,
    input  operandT  opB,
    output tagT      readTagA,
    output tagT      readTagB,
    input  readPortT readA,
    input  readPortT readB,
    input  logic     robFree,
    output logic     alloc,
    input  tagT      freeTag,
    output logic     rename,
    output regIdxT   renameDest,
    input  logic     accept,
    output issueT    issue
);

    logic  slotValid;
    instrT slotInstr;
    logic  capture;
    logic  doIssue;

    // pending tag answered by the reorder buffer becomes a value
    function automatic operandT resolve(input operandT op, input readPortT rd);
        operandT res;
        res = op;
        if (op.pending && rd.valid) begin
            res.pending = 1'b0;
            res.value   = rd.data;
        end
        return res;
    endfunction

    assign capture = req && !ack && !slotValid;
    assign doIssue = slotValid && robFree && accept;

    always_ff @(posedge clk) begin
        if (rst) begin
            slotValid <= 1'b0;
            ack       <= 1'b0;
        end else if (capture) begin
            slotValid <= 1'b1;
            ack       <= 1'b1;
        end else begin
            if (!req) begin
                ack <= 1'b0;
            end
            if (doIssue) begin
                slotValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            slotInstr <= instr;
        end
    end

    // lookups run every cycle so a waiting instruction sees current state
    assign srcA     = slotInstr.srcA;
    assign srcB     = slotInstr.srcB;
    assign readTagA = opA.tag;
    assign readTagB = opB.tag;

    assign alloc      = doIssue;
    assign rename     = doIssue;
    assign renameDest = slotInstr.dest;

    always_comb begin
        issue.valid = doIssue;
        issue.op    = slotInstr.op;
        issue.tag   = freeTag;
        issue.dest  = slotInstr.dest;
        if (slotInstr.op == OpLdi) begin
            issue.opA = '{pending: 1'b0, tag: '0, value: slotInstr.imm};
            issue.opB = '{pending: 1'b0, tag: '0, value: '0};
        end else begin
            issue.opA = resolve(opA, readA);
            issue.opB = resolve(opB, readB);
        end
    end

endmodule

//--- executeStage.sv
`timescale 1ns/10ps

module executeStage
    import robPkg::*;
#(
    parameter int MulLatency = 3
) (
    input  logic  clk,
    input  logic  rst,
    input  issueT issue,
    output logic  accept,
    output wbT    wb
);

    issueT waitOp;
    wbT    mulPipe [MulLatency];
    wbT    mulLast;
    dataT  aluResult;
    dataT  mulProduct;
    logic  opsReady;
    logic  aluGo;
    logic  mulGo;

    assign mulLast  = mulPipe[MulLatency-1];
    assign opsReady = waitOp.valid && !waitOp.opA.pending && !waitOp.opB.pending;
    assign mulGo    = opsReady && waitOp.op == OpMul;
    // a finishing multiply owns the write-back port, the ALU op stays put
    assign aluGo    = opsReady && waitOp.op != OpMul && !mulLast.valid;
    assign accept   = !waitOp.valid || aluGo || mulGo;

    always_comb begin
        case (waitOp.op)
            OpAdd:   aluResult = waitOp.opA.value + waitOp.opB.value;
            OpSub:   aluResult = waitOp.opA.value - waitOp.opB.value;
            OpXor:   aluResult = waitOp.opA.value ^ waitOp.opB.value;
            // ldi carries its immediate in opA
            default: aluResult = waitOp.opA.value;
        endcase
    end

    assign mulProduct = waitOp.opA.value * waitOp.opB.value;

    always_ff @(posedge clk) begin
        if (rst) begin
            waitOp.valid <= 1'b0;
        end else if (accept) begin
            waitOp <= issue;
        end else begin
            // snoop write-back for operands still waiting on a tag
            if (wb.valid && waitOp.opA.pending && wb.tag == waitOp.opA.tag) begin
                waitOp.opA.pending <= 1'b0;
                waitOp.opA.value   <= wb.data;
            end
            if (wb.valid && waitOp.opB.pending && wb.tag == waitOp.opB.tag) begin
                waitOp.opB.pending <= 1'b0;
                waitOp.opB.value   <= wb.data;
            end
        end
    end

    // multiplier shift pipeline carrying the tag with the product
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MulLatency; i++) begin
                mulPipe[i].valid <= 1'b0;
            end
        end else begin
            mulPipe[0].valid <= mulGo;
            for (int i = 1; i < MulLatency; i++) begin
                mulPipe[i].valid <= mulPipe[i-1].valid;
            end
        end
        mulPipe[0].tag  <= waitOp.tag;
        mulPipe[0].data <= mulProduct;
        for (int i = 1; i < MulLatency; i++) begin
            mulPipe[i].tag  <= mulPipe[i-1].tag;
            mulPipe[i].data <= mulPipe[i-1].data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= mulLast.valid || aluGo;
        end
        if (mulLast.valid) begin
            wb.tag  <= mulLast.tag;
            wb.data <= mulLast.data;
        end else begin
            wb.tag  <= waitOp.tag;
            wb.data <= aluResult;
        end
    end

endmodule

//--- reorderBuffer.sv
`timescale 1ns/10ps

module reorderBuffer
    import robPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     alloc,
    input  regIdxT   allocDest,
    output tagT      freeTag,
    output logic     robFree,
    input  wbT       wb,
    input  tagT      readTagA,
    input  tagT      readTagB,
    output readPortT readA,
    output readPortT readB,
    output commitT   commit
);

    logic [RobDepth-1:0] busy;
    logic [RobDepth-1:0] done;
    regIdxT              destMem [RobDepth];
    dataT                dataMem [RobDepth];

    tagT  head;
    tagT  tail;
    logic headDone;

    // answer for one read port, same-cycle write-back forwarded
    function automatic readPortT readEntry(input tagT t);
        readPortT res;
        res.valid = 1'b0;
        res.data  = dataMem[t];
        if (wb.valid && wb.tag == t) begin
            res.valid = 1'b1;
            res.data  = wb.data;
        end else if (busy[t] && done[t]) begin
            res.valid = 1'b1;
        end
        return res;
    endfunction

    always_comb begin
        readA = readEntry(readTagA);
        readB = readEntry(readTagB);
    end

    // tail is the next entry to hand out
    assign freeTag  = tail;
    assign robFree  = ~&busy;
    assign headDone = busy[head] && done[head];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
            done <= '0;
            head <= '0;
            tail <= '0;
        end else begin
            if (wb.valid) begin
                done[wb.tag] <= 1'b1;
            end
            if (headDone) begin
                busy[head] <= 1'b0;
                head       <= head + tagT'(1);
            end
            if (alloc) begin
                busy[tail] <= 1'b1;
                done[tail] <= 1'b0;
                tail       <= tail + tagT'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            destMem[tail] <= allocDest;
        end
        if (wb.valid) begin
            dataMem[wb.tag] <= wb.data;
        end
    end

    // at most one commit per cycle, taken from stored state only
    always_ff @(posedge clk) begin
        if (rst) begin
            commit.valid <= 1'b0;
        end else begin
            commit.valid <= headDone;
        end
        commit.tag  <= head;
        commit.dest <= destMem[head];
        commit.data <= dataMem[head];
    end

endmodule

//--- robCore.sv
`timescale 1ns/10ps

module robCore
    import robPkg::*;
#(
    parameter int MulLatency = 3
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   req,
    input  instrT  instr,
    output logic   ack,
    output commitT commit
);

    regIdxT   srcA;
    regIdxT   srcB;
    operandT  opA;
    operandT  opB;
    tagT      readTagA;
    tagT      readTagB;
    readPortT readA;
    readPortT readB;
    logic     robFree;
    logic     alloc;
    tagT      freeTag;
    logic     rename;
    regIdxT   renameDest;
    logic     accept;
    issueT    issue;
    wbT       wb;

    regStatus regStatus0 (
        .clk        (clk),
        .rst        (rst),
        .srcA       (srcA),
        .srcB       (srcB),
        .opA        (opA),
        .opB        (opB),
        .rename     (rename),
        .renameDest (renameDest),
        .renameTag  (freeTag),
        .commit     (commit)
    );

    dispatchStage dispatchStage0 (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .ack        (ack),
        .instr      (instr),
        .srcA       (srcA),
        .srcB       (srcB),
        .opA        (opA),
        .opB        (opB),
        .readTagA   (readTagA),
        .readTagB   (readTagB),
        .readA      (readA),
        .readB      (readB),
        .robFree    (robFree),
        .alloc      (alloc),
        .freeTag    (freeTag),
        .rename     (rename),
        .renameDest (renameDest),
        .accept     (accept),
        .issue      (issue)
    );

    executeStage #(
        .MulLatency (MulLatency)
    ) executeStage0 (
        .clk    (clk),
        .rst    (rst),
        .issue  (issue),
        .accept (accept),
        .wb     (wb)
    );

    // allocation dest is the renamed register
    reorderBuffer reorderBuffer0 (
        .clk       (clk),
        .rst       (rst),
        .alloc     (alloc),
        .allocDest (renameDest),
        .freeTag   (freeTag),
        .robFree   (robFree),
        .wb        (wb),
        .readTagA  (readTagA),
        .readTagB  (readTagB),
        .readA     (readA),
        .readB     (readB),
        .commit    (commit)
    );

endmodule

//--- tbClock.sv
`timescale 1ns/10ps

module tbClock #(
    parameter int PeriodNs    = 4,
    parameter int ResetCycles = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PeriodNs / 2.0) clk = ~clk;
    end

    // reset released on the last of the reset edges
    initial begin
        rst = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- robCore_assert.sv
`timescale 1ns/10ps

module robCoreAssert
    import robPkg::*;
(
    input logic   clk,
    input logic   rst,
    input logic   alloc,
    input commitT commit
);

    tagT         nextTag;
    int          occupied;
    int unsigned failCount = 0;

    // tag expected on the next commit of the circular buffer
    always_ff @(posedge clk) begin
        if (rst) begin
            nextTag <= '0;
        end else if (commit.valid) begin
            nextTag <= nextTag + tagT'(1);
        end
    end

    // entries held, counted from alloc and commit pulses only
    always_ff @(posedge clk) begin
        if (rst) begin
            occupied <= 0;
        end else begin
            occupied <= occupied + int'(alloc) - int'(commit.valid);
        end
    end

    // the committing entry still counts as held until this cycle ends
    commitNotEmpty: assert property (@(posedge clk) disable iff (rst)
        commit.valid |-> occupied != 0)
        else begin
            $error("commit while the reorder buffer was empty");
            failCount++;
        end

    commitInOrder: assert property (@(posedge clk) disable iff (rst)
        commit.valid |-> commit.tag == nextTag)
        else begin
            $error("commit tag %0d out of order, next tag is %0d", commit.tag, nextTag);
            failCount++;
        end

    // an entry whose commit shows this cycle is already free
    allocWhenFree: assert property (@(posedge clk) disable iff (rst)
        alloc |-> occupied - int'(commit.valid) < RobDepth)
        else begin
            $error("allocation while the reorder buffer was full");
            failCount++;
        end

endmodule

//--- tbTop.sv
`timescale 1ns/10ps

module tbTop
    import robPkg::*;
();

    localparam int          MulLatency   = 40;
    localparam int          ClkPeriod    = 4;
    localparam int          ResetCycles  = 10;
    localparam int          TotalInstr   = 234;
    localparam int          AckTimeout   = 4 * (MulLatency + 20);
    localparam int          DrainTimeout = (RobDepth + 2) * (MulLatency + 20);
    localparam logic [31:0] LfsrSeed     = 32'h8d7e73a3;
    localparam logic [31:0] LfsrTaps     = 32'h80200003;

    typedef struct packed {
        tagT    tag;
        regIdxT dest;
        dataT   data;
    } expT;

    logic   clk;
    logic   rst;
    logic   req;
    instrT  instr;
    logic   ack;
    commitT commit;

    dataT        modelRegs [8];
    expT         expQ [$];
    tagT         wbLog [$];
    logic [31:0] lfsrState;
    int          sentCount;
    int          lastAckWait;
    int          errorCount;
    int          monitorErrors;
    int          checkCount;
    int          testCount;
    int          fullCycles;

    tbClock #(.PeriodNs(ClkPeriod), .ResetCycles(ResetCycles)) clkGen0 (
        .clk (clk),
        .rst (rst)
    );

    robCore #(.MulLatency(MulLatency)) dut0 (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .instr  (instr),
        .ack    (ack),
        .commit (commit)
    );

    bind reorderBuffer robCoreAssert assertChecks0 (
        .clk     (clk),
        .rst     (rst),
        .alloc   (alloc),
        .commit  (commit)
    );

    function automatic logic nextBit();
        logic outBit;
        outBit    = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) begin
            lfsrState = lfsrState ^ LfsrTaps;
        end
        return outBit;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] res;
        res = '0;
        for (int i = 0; i < n; i++) begin
            res = {res[30:0], nextBit()};
        end
        return res;
    endfunction

    function automatic dataT modelResult(input opCodeT op, input dataT a, input dataT b,
                                         input dataT imm);
        dataT res;
        case (op)
            OpAdd:   res = a + b;
            OpSub:   res = a - b;
            OpXor:   res = a ^ b;
            OpMul:   res = a * b;
            default: res = imm;
        endcase
        return res;
    endfunction

    // model runs in program order and hands out tags circularly
    task automatic sendInstr(input opCodeT op, input regIdxT dest, input regIdxT srcA,
                             input regIdxT srcB, input dataT imm);
        expT expected;
        int  waitCycles;
        expected.tag   = tagT'(sentCount);
        expected.dest  = dest;
        expected.data  = modelResult(op, modelRegs[srcA], modelRegs[srcB], imm);
        modelRegs[dest] = expected.data;
        expQ.push_back(expected);
        sentCount++;
        @(negedge clk);
        assert (!ack) else begin
            $display("ack still high when a new request started at %0t", $time);
            errorCount++;
        end
        @(posedge clk);
        req   <= 1'b1;
        instr <= '{op: op, dest: dest, srcA: srcA, srcB: srcB, imm: imm};
        waitCycles = 0;
        do begin
            @(negedge clk);
            waitCycles++;
        end while (!ack && waitCycles < AckTimeout);
        lastAckWait = waitCycles;
        assert (ack) else begin
            $display("no ack within %0d cycles at %0t", AckTimeout, $time);
            errorCount++;
        end
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        @(negedge clk);
        assert (!ack) else begin
            $display("ack did not fall one cycle after req was released at %0t", $time);
            errorCount++;
        end
    endtask

    task automatic drain();
        int waitCycles;
        waitCycles = 0;
        while (expQ.size() != 0 && waitCycles < DrainTimeout) begin
            @(posedge clk);
            waitCycles++;
        end
        assert (expQ.size() == 0) else begin
            $display("%0d results never committed at %0t", expQ.size(), $time);
            errorCount++;
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        testCount++;
        $display("test %s: %0d errors", name, errorCount + monitorErrors - errorsBefore);
    endtask

    task automatic testLdiAdd();
        int errorsBefore;
        errorsBefore = errorCount + monitorErrors;
        sendInstr(OpLdi, 3'd1, 3'd0, 3'd0, 32'h0000_1234);
        sendInstr(OpLdi, 3'd2, 3'd0, 3'd0, 32'hffff_0001);
        drain();
        sendInstr(OpAdd, 3'd3, 3'd1, 3'd2, '0);
        sendInstr(OpLdi, 3'd5, 3'd0, 3'd0, 32'h5a5a_0f0f);
        sendInstr(OpAdd, 3'd4, 3'd1, 3'd1, '0);
        drain();
        reportTest("ldiAdd", errorsBefore);
    endtask

    // the slow multiply keeps younger results parked in the buffer
    task automatic testChain();
        int errorsBefore;
        errorsBefore = errorCount + monitorErrors;
        sendInstr(OpLdi, 3'd1, 3'd0, 3'd0, 32'd5);
        sendInstr(OpLdi, 3'd2, 3'd0, 3'd0, 32'd7);
        sendInstr(OpMul, 3'd3, 3'd1, 3'd2, '0);
        sendInstr(OpAdd, 3'd4, 3'd1, 3'd2, '0);
        sendInstr(OpSub, 3'd5, 3'd4, 3'd1, '0);
        sendInstr(OpXor, 3'd6, 3'd5, 3'd4, '0);
        sendInstr(OpAdd, 3'd7, 3'd3, 3'd6, '0);
        sendInstr(OpSub, 3'd1, 3'd7, 3'd5, '0);
        drain();
        reportTest("chain", errorsBefore);
    endtask

    task automatic testMulBypass();
        int  errorsBefore;
        int  wbStart;
        tagT mulTag;
        errorsBefore = errorCount + monitorErrors;
        sendInstr(OpLdi, 3'd1, 3'd0, 3'd0, 32'h0001_0003);
        sendInstr(OpLdi, 3'd2, 3'd0, 3'd0, 32'h0000_0101);
        drain();
        wbStart = wbLog.size();
        mulTag  = tagT'(sentCount);
        sendInstr(OpMul, 3'd3, 3'd1, 3'd2, '0);
        sendInstr(OpAdd, 3'd4, 3'd1, 3'd2, '0);
        sendInstr(OpXor, 3'd5, 3'd1, 3'd2, '0);
        sendInstr(OpSub, 3'd6, 3'd2, 3'd1, '0);
        sendInstr(OpLdi, 3'd7, 3'd0, 3'd0, 32'h0000_00c3);
        drain();
        assert (wbLog.size() > wbStart && wbLog[$] == mulTag) else begin
            $display("multiply did not write back after the younger ALU ops");
            errorCount++;
        end
        reportTest("mulBypass", errorsBefore);
    endtask

    task automatic testFullBuffer();
        int errorsBefore;
        int fullBefore;
        int maxWait;
        errorsBefore = errorCount + monitorErrors;
        maxWait      = 0;
        sendInstr(OpLdi, 3'd1, 3'd0, 3'd0, 32'd3);
        sendInstr(OpLdi, 3'd2, 3'd0, 3'd0, 32'h0101_0101);
        drain();
        fullBefore = fullCycles;
        for (int i = 0; i < 12; i++) begin
            sendInstr(OpMul, regIdxT'(3 + i % 5), 3'd1, 3'd2, '0);
            if (lastAckWait > maxWait) begin
                maxWait = lastAckWait;
            end
        end
        drain();
        assert (fullCycles > fullBefore) else begin
            $display("reorder buffer never became full");
            errorCount++;
        end
        // an unhindered handshake sees ack on the second falling edge
        assert (maxWait > 2) else begin
            $display("ack was never withheld while the buffer was full");
            errorCount++;
        end
        reportTest("fullBuffer", errorsBefore);
    endtask

    task automatic testRandomMix();
        int     errorsBefore;
        opCodeT op;
        regIdxT dest;
        regIdxT srcA;
        regIdxT srcB;
        dataT   imm;
        errorsBefore = errorCount + monitorErrors;
        for (int i = 0; i < 200; i++) begin
            case (randBits(3) % 32'd5)
                0:       op = OpAdd;
                1:       op = OpSub;
                2:       op = OpXor;
                3:       op = OpMul;
                default: op = OpLdi;
            endcase
            dest = regIdxT'(randBits(3));
            srcA = regIdxT'(randBits(3));
            srcB = regIdxT'(randBits(3));
            imm  = randBits(32);
            sendInstr(op, dest, srcA, srcB, imm);
        end
        drain();
        reportTest("randomMix", errorsBefore);
    endtask

    always @(negedge clk) begin
        expT expected;
        if (!rst && commit.valid) begin
            checkCount++;
            assert (expQ.size() != 0) else begin
                $display("commit of tag %0d with no instruction outstanding at %0t",
                         commit.tag, $time);
                monitorErrors++;
            end
            if (expQ.size() != 0) begin
                expected = expQ.pop_front();
                assert (commit.tag == expected.tag) else begin
                    $display("Mismatch at %0t: commit.tag got %0d expected %0d",
                             $time, commit.tag, expected.tag);
                    monitorErrors++;
                end
                assert (commit.dest == expected.dest) else begin
                    $display("Mismatch at %0t: commit.dest got %0d expected %0d",
                             $time, commit.dest, expected.dest);
                    monitorErrors++;
                end
                assert (commit.data == expected.data) else begin
                    $display("Mismatch at %0t: commit.data got %h expected %h",
                             $time, commit.data, expected.data);
                    monitorErrors++;
                end
            end
        end
        // internal views for the ordering and back-pressure tests
        if (!rst && dut0.wb.valid) begin
            wbLog.push_back(dut0.wb.tag);
        end
        if (!rst && !dut0.robFree) begin
            fullCycles++;
        end
    end

    initial begin
        #((ResetCycles + TotalInstr * (MulLatency + 20)) * ClkPeriod);
        $display("watchdog expired before the tests finished");
        $display("sim failed");
        $finish;
    end

    initial begin
        int assertFails;
        req           = 1'b0;
        instr         = '0;
        lfsrState     = LfsrSeed;
        sentCount     = 0;
        lastAckWait   = 0;
        errorCount    = 0;
        monitorErrors = 0;
        checkCount    = 0;
        testCount     = 0;
        fullCycles    = 0;
        for (int i = 0; i < 8; i++) begin
            modelRegs[i] = '0;
        end
        wait (rst === 1'b0);
        @(negedge clk);
        testLdiAdd();
        testChain();
        testMulBypass();
        testFullBuffer();
        testRandomMix();
        assertFails = dut0.reorderBuffer0.assertChecks0.failCount;
        $display("tests %0d, commits checked %0d, errors %0d, assertion failures %0d",
                 testCount, checkCount, errorCount + monitorErrors, assertFails);
        if (errorCount + monitorErrors == 0 && assertFails == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- robCore.f
robPkg.sv
regStatus.sv
dispatchStage.sv
executeStage.sv
reorderBuffer.sv
robCore.sv
tbClock.sv
robCore_assert.sv
tbTop.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tbTop -f robCore.f -o simTop
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build returned status $status"
    exit 1
fi

./obj_dir/simTop +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if grep -q "sim failed" sim.log; then
    exit 1
fi
if ! grep -q "sim passed" sim.log; then
    echo "no pass line found in sim.log"
    exit 1
fi
exit 0
